// ==== include/render_params.svh ====
`ifndef RENDER_PARAMS_SVH
`define RENDER_PARAMS_SVH

// ----------------------------------------------------------------------------
// Frame geometry
// ----------------------------------------------------------------------------
`define FB_WIDTH      32                      // Pixels per row
`define FB_HEIGHT     8                       // Rows per frame

// Coordinate widths, must cover WIDTH-1 and HEIGHT-1
`define FB_X_BITS     5
`define FB_Y_BITS     3

// Frame address is {y, x}
`define FB_ADDR_BITS  (`FB_X_BITS + `FB_Y_BITS)

`endif

// ==== rtl/render_pkg.sv ====
`default_nettype none

`include "render_params.svh"

package render_pkg;

    // Red, green, blue nibbles from high to low
    typedef logic [11:0] color12_t;

    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_FILL = 4'h1,
        OP_SPAN = 4'h2                        // Anything else decodes as NOP
    } render_op_e;

    // ------------------------------------------------------------------------
    // Command word views, opcode in the top nibble of both
    // ------------------------------------------------------------------------
    typedef struct packed {
        render_op_e  op;
        logic [15:0] reserved;
        color12_t    color;
    } fill_cmd_t;

    typedef struct packed {
        render_op_e  op;
        logic [5:0]  x_start;
        logic [5:0]  x_end;                   // Inclusive, clipped to the frame
        logic [3:0]  y;
        color12_t    color;
    } span_cmd_t;

    typedef union packed {
        fill_cmd_t fill;
        span_cmd_t span;
    } render_cmd_u;

    // Span fields reach at most 64 columns and 16 rows
    localparam bit CMD_FITS_FRAME = (`FB_WIDTH <= 64) && (`FB_HEIGHT <= 16);

endpackage

`default_nettype wire

// ==== rtl/span_rasterizer.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "render_params.svh"

module span_rasterizer (
    input  wire logic                    clk_render,
    input  wire logic                    btn_rst_n,
    input  wire logic                    cmd_strobe,
    input  wire render_pkg::render_cmd_u cmd_word,
    output      logic                    busy,
    output      logic                    wr_en,
    output      logic [`FB_X_BITS-1:0]   wr_x,
    output      logic [`FB_Y_BITS-1:0]   wr_y,
    output      render_pkg::color12_t    wr_color
);

    import render_pkg::*;

    localparam int X_BITS = `FB_X_BITS;
    localparam int Y_BITS = `FB_Y_BITS;

    // Last column and row in command field widths
    localparam logic [5:0] LAST_X = 6'(`FB_WIDTH - 1);
    localparam logic [3:0] LAST_Y = 4'(`FB_HEIGHT - 1);

    if (!CMD_FITS_FRAME) begin : g_frame_too_big
        $error("Frame geometry does not fit the span command fields");
    end

    render_cmd_u       cmd_q;                 // Held command word
    render_op_e        op;
    logic              accept;
    logic              decode_pend;           // Decode cycle after accept
    logic [5:0]        span_x_end;
    logic              span_ok;
    logic [X_BITS-1:0] end_x;
    logic [Y_BITS-1:0] end_y;
    logic              last_x;
    logic              last_pix;

    assign accept = cmd_strobe && !busy;
    assign op     = cmd_q.fill.op;            // Same nibble in the span view

    // Clip the span end to the frame, then reject empty or off-frame spans
    assign span_x_end = (cmd_q.span.x_end > LAST_X) ? LAST_X : cmd_q.span.x_end;
    assign span_ok    = (cmd_q.span.y <= LAST_Y) && (cmd_q.span.x_start <= span_x_end);

    assign last_x   = (wr_x == end_x);
    assign last_pix = last_x && (wr_y == end_y);

    // ------------------------------------------------------------------------
    // Control and write counters
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_render or negedge btn_rst_n) begin
        if (!btn_rst_n) begin
            busy        <= 1'b0;
            decode_pend <= 1'b0;
            wr_en       <= 1'b0;
            wr_x        <= '0;
            wr_y        <= '0;
        end else if (accept) begin
            busy        <= 1'b1;
            decode_pend <= 1'b1;
        end else if (decode_pend) begin
            decode_pend <= 1'b0;
            case (op)
                OP_FILL: begin
                    wr_en <= 1'b1;
                    wr_x  <= '0;
                    wr_y  <= '0;
                end
                OP_SPAN: begin
                    if (span_ok) begin
                        wr_en <= 1'b1;
                        wr_x  <= X_BITS'(cmd_q.span.x_start);
                        wr_y  <= Y_BITS'(cmd_q.span.y);
                    end else begin
                        busy  <= 1'b0;        // Nothing to draw
                    end
                end
                default: busy <= 1'b0;
            endcase
        end else if (wr_en) begin
            if (last_pix) begin
                wr_en <= 1'b0;
                busy  <= 1'b0;
            end else if (last_x) begin
                wr_x  <= '0;                  // Fills wrap to the next row
                wr_y  <= wr_y + 1'b1;
            end else begin
                wr_x  <= wr_x + 1'b1;
            end
        end
    end

    // Command word, end point and color
    always_ff @(posedge clk_render) begin
        if (accept) begin
            cmd_q <= cmd_word;
        end
        if (decode_pend) begin
            wr_color <= cmd_q.fill.color;     // Same bits in both views
            if (op == OP_FILL) begin
                end_x <= X_BITS'(LAST_X);
                end_y <= Y_BITS'(LAST_Y);
            end else begin
                end_x <= X_BITS'(span_x_end);
                end_y <= Y_BITS'(cmd_q.span.y);
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/frame_store.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "render_params.svh"

module frame_store (
    input  wire logic                  clk_render,
    input  wire logic                  wr_en,
    input  wire logic [`FB_X_BITS-1:0] wr_x,
    input  wire logic [`FB_Y_BITS-1:0] wr_y,
    input  wire render_pkg::color12_t  wr_color,
    input  wire logic [`FB_X_BITS-1:0] rd_x,
    input  wire logic [`FB_Y_BITS-1:0] rd_y,
    output      render_pkg::color12_t  rd_color
);

    import render_pkg::*;

    // One entry per {y, x} code
    localparam int DEPTH = 2 ** `FB_ADDR_BITS;

    color12_t                 mem [DEPTH];
    logic [`FB_ADDR_BITS-1:0] wr_addr;
    logic [`FB_ADDR_BITS-1:0] rd_addr;

    assign wr_addr = {wr_y, wr_x};
    assign rd_addr = {rd_y, rd_x};

    always_ff @(posedge clk_render) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_color;
        end
    end

    // Registered read, one cycle latency
    always_ff @(posedge clk_render) begin
        rd_color <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== rtl/scanout_reader.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "render_params.svh"

module scanout_reader (
    input  wire logic                  clk_render,
    input  wire logic                  btn_rst_n,
    input  wire logic                  scan_start,
    input  wire render_pkg::color12_t  rd_color,
    output      logic                  scan_busy,
    output      logic [`FB_X_BITS-1:0] rd_x,
    output      logic [`FB_Y_BITS-1:0] rd_y,
    output      logic                  pix_valid,
    output      logic [`FB_X_BITS-1:0] pix_x,
    output      logic [`FB_Y_BITS-1:0] pix_y,
    output      render_pkg::color12_t  pix_color
);

    localparam int X_BITS = `FB_X_BITS;
    localparam int Y_BITS = `FB_Y_BITS;
    localparam logic [X_BITS-1:0] LAST_X = X_BITS'(`FB_WIDTH - 1);
    localparam logic [Y_BITS-1:0] LAST_Y = Y_BITS'(`FB_HEIGHT - 1);

    logic accept;
    logic start_q;                            // Address phase opens next cycle
    logic addr_valid;
    logic addr_last;
    logic pix_last;

    assign accept    = scan_start && !scan_busy;
    assign addr_last = (rd_x == LAST_X) && (rd_y == LAST_Y);
    assign pix_last  = (pix_x == LAST_X) && (pix_y == LAST_Y);

    // ------------------------------------------------------------------------
    // Address phase
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_render or negedge btn_rst_n) begin
        if (!btn_rst_n) begin
            scan_busy  <= 1'b0;
            start_q    <= 1'b0;
            addr_valid <= 1'b0;
            rd_x       <= '0;
            rd_y       <= '0;
        end else begin
            start_q <= accept;
            if (accept) begin
                scan_busy <= 1'b1;
                rd_x      <= '0;
                rd_y      <= '0;
            end else if (pix_valid && pix_last) begin
                scan_busy <= 1'b0;            // Drops with the final pixel
            end

            if (start_q) begin
                addr_valid <= 1'b1;
            end else if (addr_valid) begin
                if (addr_last) begin
                    addr_valid <= 1'b0;
                end else if (rd_x == LAST_X) begin
                    rd_x <= '0;
                    rd_y <= rd_y + 1'b1;
                end else begin
                    rd_x <= rd_x + 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Data phase, matched to the read latency
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_render or negedge btn_rst_n) begin
        if (!btn_rst_n) begin
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= addr_valid;
        end
    end

    always_ff @(posedge clk_render) begin
        pix_x <= rd_x;
        pix_y <= rd_y;
    end

    assign pix_color = rd_color;              // Already registered in the store

endmodule

`default_nettype wire

// ==== rtl/render_top.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "render_params.svh"

module render_top (
    input  wire logic                  clk_render,
    input  wire logic                  btn_rst_n,
    input  wire logic                  cmd_strobe,
    input  wire logic [31:0]           cmd_word,
    input  wire logic                  scan_start,
    output      logic                  busy,
    output      logic                  scan_busy,
    output      logic                  pix_valid,
    output      logic [`FB_X_BITS-1:0] pix_x,
    output      logic [`FB_Y_BITS-1:0] pix_y,
    output      render_pkg::color12_t  pix_color
);

    import render_pkg::*;

    // ------------------------------------------------------------------------
    // Producer side, commands into pixel writes
    // ------------------------------------------------------------------------
    logic                  wr_en;
    logic [`FB_X_BITS-1:0] wr_x;
    logic [`FB_Y_BITS-1:0] wr_y;
    color12_t              wr_color;

    span_rasterizer u_span_rasterizer (
        .clk_render (clk_render),
        .btn_rst_n  (btn_rst_n),
        .cmd_strobe (cmd_strobe),
        .cmd_word   (cmd_word),               // Raw word seen through the union
        .busy       (busy),
        .wr_en      (wr_en),
        .wr_x       (wr_x),
        .wr_y       (wr_y),
        .wr_color   (wr_color)
    );

    // ------------------------------------------------------------------------
    // Frame memory
    // ------------------------------------------------------------------------
    logic [`FB_X_BITS-1:0] rd_x;
    logic [`FB_Y_BITS-1:0] rd_y;
    color12_t              rd_color;

    frame_store u_frame_store (
        .clk_render (clk_render),
        .wr_en      (wr_en),
        .wr_x       (wr_x),
        .wr_y       (wr_y),
        .wr_color   (wr_color),
        .rd_x       (rd_x),
        .rd_y       (rd_y),
        .rd_color   (rd_color)
    );

    // Consumer side
    scanout_reader u_scanout_reader (
        .clk_render (clk_render),
        .btn_rst_n  (btn_rst_n),
        .scan_start (scan_start),
        .rd_color   (rd_color),
        .scan_busy  (scan_busy),
        .rd_x       (rd_x),
        .rd_y       (rd_y),
        .pix_valid  (pix_valid),
        .pix_x      (pix_x),
        .pix_y      (pix_y),
        .pix_color  (pix_color)
    );

endmodule

`default_nettype wire

// ==== tb/render_chk.sv ====
`default_nettype none
`timescale 1ns/1ns

module render_chk (
    input wire logic clk_render,
    input wire logic btn_rst_n,
    input wire logic start,                   // Command or scan strobe
    input wire logic busy,
    input wire logic valid                    // Pixel write or pixel out
);

    int err_count = 0;

    // ------------------------------------------------------------------------
    // Strobe and busy rules
    // ------------------------------------------------------------------------
    valid_inside_busy: assert property (
        @(posedge clk_render) disable iff (!btn_rst_n) valid |-> busy
    ) else begin
        $error("Output activity while busy is low");
        err_count++;
    end

    // Decode or address phase comes first
    no_valid_after_start: assert property (
        @(posedge clk_render) disable iff (!btn_rst_n) (start && !busy) |=> !valid
    ) else begin
        $error("Output activity in the cycle after an accepted strobe");
        err_count++;
    end

    quiet_after_reset: assert property (
        @(posedge clk_render) $rose(btn_rst_n) |-> (!busy && !valid)
    ) else begin
        $error("Busy or valid high right after reset release");
        err_count++;
    end

endmodule

bind span_rasterizer render_chk u_render_chk (.clk_render(clk_render),
    .btn_rst_n(btn_rst_n), .start(cmd_strobe), .busy(busy), .valid(wr_en));

bind scanout_reader render_chk u_render_chk (.clk_render(clk_render),
    .btn_rst_n(btn_rst_n), .start(scan_start), .busy(scan_busy), .valid(pix_valid));

`default_nettype wire

// ==== tb/tb_render_top.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "render_params.svh"

module tb_render_top;

    localparam int W      = `FB_WIDTH;
    localparam int H      = `FB_HEIGHT;
    localparam int PIXELS = W * H;
    localparam logic [31:0] DECOY_WORD = 32'h1000_0bad;  // Fill sent while busy

    logic                  clk_render = 1'b0;
    logic                  btn_rst_n  = 1'b0;
    logic                  cmd_strobe = 1'b0;
    logic [31:0]           cmd_word   = '0;
    logic                  scan_start = 1'b0;
    logic                  busy;
    logic                  scan_busy;
    logic                  pix_valid;
    logic [`FB_X_BITS-1:0] pix_x;
    logic [`FB_Y_BITS-1:0] pix_y;
    logic [11:0]           pix_color;

    logic [11:0] model_img [H][W];             // Reference image
    byte         step_kind [$];
    int          step_a [$];
    int          step_b [$];
    int          step_c [$];
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          assert_fails;

    render_top u_render_top (
        .clk_render (clk_render),
        .btn_rst_n  (btn_rst_n),
        .cmd_strobe (cmd_strobe),
        .cmd_word   (cmd_word),
        .scan_start (scan_start),
        .busy       (busy),
        .scan_busy  (scan_busy),
        .pix_valid  (pix_valid),
        .pix_x      (pix_x),
        .pix_y      (pix_y),
        .pix_color  (pix_color)
    );

    always #50 clk_render = ~clk_render;

    always @(posedge clk_render) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            report_failure($sformatf("Timeout, the run went past %0d cycles", cycle_limit));
        end else if (u_render_top.u_span_rasterizer.u_render_chk.err_count != 0 ||
                     u_render_top.u_scanout_reader.u_render_chk.err_count != 0) begin
            report_failure("A bound assertion failed, see the error above");
        end
    end

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "Stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("[ERROR] %s: expected %0h, actual %0h",
                                     name, expected, actual));
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus file and reference model
    // ------------------------------------------------------------------------
    task automatic read_stimulus();
        int    fd;
        int    n;
        int    n_cmd;
        int    n_scan;
        string line;
        byte   kind;
        int    a;
        int    b;
        int    c;
        n_cmd  = 0;
        n_scan = 0;
        fd = $fopen("tb/render_input.txt", "r");
        if (fd == 0) begin
            report_failure("Could not open the stimulus file tb/render_input.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
                continue;
            end
            kind = line[0];
            case (kind)
                "C": n = $sscanf(line, "C %h", a) - 1;
                "S": n = 0;
                "P": n = $sscanf(line, "P %d %d %h", a, b, c) - 3;
                default: n = -1;
            endcase
            if (n != 0 || (kind == "P" && (a >= W || b >= H))) begin
                report_failure($sformatf("Stimulus file has a line that cannot be used: %s",
                                         line));
            end
            if (kind == "C") n_cmd++;
            if (kind == "S") n_scan++;
            step_kind.push_back(kind);
            step_a.push_back(a);
            step_b.push_back(b);
            step_c.push_back(c);
        end
        $fclose(fd);
        // Twice the worst case per step with handshake and gap cycles
        cycle_limit = 2 * (8 + n_cmd * (PIXELS + 7) + n_scan * (PIXELS + 8));
    endtask

    // Returns the number of pixel writes the command should make
    function automatic int apply_model(input logic [31:0] word);
        int          xs;
        int          xe;
        int          y;
        int          n;
        logic [11:0] color;
        xs    = int'(word[27:22]);
        xe    = int'(word[21:16]);
        y     = int'(word[15:12]);
        color = word[11:0];
        n     = 0;
        if (word[31:28] == 4'h1) begin
            for (int r = 0; r < H; r++) begin
                for (int x = 0; x < W; x++) model_img[r][x] = color;
            end
            n = PIXELS;
        end else if (word[31:28] == 4'h2) begin
            if (xe > W - 1) xe = W - 1;          // Clip to last column
            if (y < H && xs <= xe) begin
                for (int x = xs; x <= xe; x++) model_img[y][x] = color;
                n = xe - xs + 1;
            end
        end
        return n;
    endfunction

    // ------------------------------------------------------------------------
    // Bus sequences
    // ------------------------------------------------------------------------
    task automatic wait_idle();
        int gap;
        gap = int'($urandom % 4);
        @(posedge clk_render);
        while (busy || scan_busy) @(posedge clk_render);
        repeat (gap) @(posedge clk_render);
    endtask

    task automatic run_command(input logic [31:0] word);
        int busy_cycles;
        wait_idle();
        cmd_strobe <= 1'b1;
        cmd_word   <= word;
        @(posedge clk_render);
        cmd_word   <= DECOY_WORD;              // Lands while busy and must be dropped
        @(posedge clk_render);
        cmd_strobe <= 1'b0;
        busy_cycles = 0;
        while (busy) begin
            busy_cycles++;
            @(posedge clk_render);
        end
        check_value($sformatf("busy length for command %08h", word),
                    apply_model(word) + 1, busy_cycles);
    endtask

    task automatic run_scan();
        wait_idle();
        scan_start <= 1'b1;
        @(posedge clk_render);
        scan_start <= 1'b0;
        repeat (2) begin
            @(posedge clk_render);
            check_value("pix_valid before first pixel", 0, 32'(pix_valid));
        end
        for (int i = 0; i < PIXELS; i++) begin
            @(posedge clk_render);
            check_value("pix_valid during scan", 1, 32'(pix_valid));
            check_value("scan_busy during scan", 1, 32'(scan_busy));
            check_value("pix_x raster order", i % W, 32'(pix_x));
            check_value("pix_y raster order", i / W, 32'(pix_y));
            check_value($sformatf("pix_color at (%0d,%0d)", i % W, i / W),
                        32'(model_img[i / W][i % W]), 32'(pix_color));
        end
        @(posedge clk_render);
        check_value("pix_valid after scan", 0, 32'(pix_valid));
        check_value("scan_busy after scan", 0, 32'(scan_busy));
    endtask

    initial begin
        void'($urandom(69));
        read_stimulus();
        repeat (4) @(posedge clk_render);
        btn_rst_n <= 1'b1;
        @(posedge clk_render);
        check_value("busy after reset", 0, 32'(busy));
        check_value("scan_busy after reset", 0, 32'(scan_busy));
        check_value("pix_valid after reset", 0, 32'(pix_valid));
        foreach (step_kind[i]) begin
            case (step_kind[i])
                "C": run_command(step_a[i]);
                "S": run_scan();
                default: check_value($sformatf("file color at (%0d,%0d)", step_a[i], step_b[i]),
                                     step_c[i], 32'(model_img[step_b[i]][step_a[i]]));
            endcase
        end
        assert_fails = u_render_top.u_span_rasterizer.u_render_chk.err_count
                     + u_render_top.u_scanout_reader.u_render_chk.err_count;
        if (assert_fails == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            report_failure($sformatf("%0d assertion failures were seen", assert_fails));
        end
    end

endmodule

`default_nettype wire

// ==== tb/render_input.txt ====
# C <hex word> command, S scan, P <x> <y> <hex color> expected pixel
# Word: op[31:28] x_start[27:22] x_end[21:16] y[15:12] color[11:0]
C 10000123
P 0 0 123
P 31 7 123
S
C 210A2F00
C 273F50F0
C 20059ABC
C 2A32100F
C 22430777
C 00000000
C F0000FFF
C 27DF70AB
P 3 2 123
P 4 2 F00
P 10 2 F00
P 11 2 123
P 27 5 123
P 28 5 0F0
P 31 5 0F0
P 31 7 0AB
S

// ==== project.f ====
+incdir+include
rtl/render_pkg.sv
rtl/span_rasterizer.sv
rtl/frame_store.sv
rtl/scanout_reader.sv
rtl/render_top.sv
tb/render_chk.sv
tb/tb_render_top.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_render_top
FILELIST = project.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf $(OBJ_DIR)
